// File: hdl/rhd_defs.svh
`ifndef RHD_DEFS_SVH
`define RHD_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// array geometry
`define RHD_MISO_LINES      4   // miso lines, two adc words each.
`define RHD_ADC_CHANNELS    32  // convert channels per frame.
`define RHD_FRAME_XFERS     40  // convert plus flush transactions.
`define RHD_CONVERT_DELAY   2   // reply lag in transactions.

// ~~~~~~~~~~~~~~~~~~~~
// command and data words
`define RHD_SAMPLE_BITS     16
`define RHD_CHIP_ID_REG     63  // read by the flush commands.

// ~~~~~~~~~~~~~~~~~~~~
// spi timing in clk cycles
`define RHD_SCLK_HALF       2   // per sclk half period.
`define RHD_CS_GAP          3   // cs high between transactions.

`endif

// File: hdl/rhd_pkg.sv
`default_nettype none

`include "rhd_defs.svh"

package rhd_pkg;

    typedef logic [`RHD_SAMPLE_BITS-1:0] sample_t;
    typedef logic [`RHD_SAMPLE_BITS-1:0] cmd_word_t;
    typedef logic [5:0] channel_t;   // channel or transaction index.

    // position of a sample in the streamed frame.
    typedef logic [$clog2(2 * `RHD_MISO_LINES * `RHD_ADC_CHANNELS)-1:0] sample_index_t;

    typedef struct packed {
        sample_t b;   // word clocked on the falling edge.
        sample_t a;   // word clocked on the rising edge.
    } line_reply_t;

    typedef line_reply_t [`RHD_MISO_LINES-1:0] frame_row_t;   // line 0 in the low bits.

    typedef struct packed {
        logic       en;
        channel_t   addr;
        frame_row_t row;
    } row_write_t;

    typedef enum logic [2:0] {
        READY,
        LOAD,
        TX,
        RX,
        STREAM
    } seq_state_t;

endpackage

`default_nettype wire

// File: hdl/rhd_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

`include "rhd_defs.svh"

module rhd_sequencer (
    input  wire                  clk,
    input  wire                  rstn,
    input  wire                  record_start,
    input  wire                  xfer_busy,
    input  wire                  xfer_done,
    input  wire                  stream_done,
    input  wire rhd_pkg::frame_row_t reply,
    output logic                 xfer_start,
    output rhd_pkg::cmd_word_t   xfer_cmd,
    output rhd_pkg::row_write_t  store_wr,
    output logic                 stream_start,
    output rhd_pkg::channel_t    channel,
    output logic                 busy,
    output logic                 done
);

    import rhd_pkg::*;

    localparam channel_t CONVERT_DELAY = channel_t'(`RHD_CONVERT_DELAY);
    localparam channel_t ADC_CHANNELS  = channel_t'(`RHD_ADC_CHANNELS);
    localparam channel_t LAST_XFER     = channel_t'(`RHD_FRAME_XFERS - 1);
    localparam channel_t CHIP_ID_REG   = channel_t'(`RHD_CHIP_ID_REG);

    seq_state_t state;
    cmd_word_t  convert_cmd;
    cmd_word_t  read_cmd;
    channel_t   row_addr;
    logic       in_window;
    logic       last_xfer;

    // ~~~~~~~~~~~~~~~~~~~~
    // command words
    assign convert_cmd = {2'b00, channel, 7'd0, 1'b1};   // offset removal on.
    assign read_cmd    = {2'b11, CHIP_ID_REG, 8'd0};

    // replies lag the commands by the convert delay.
    assign row_addr  = channel - CONVERT_DELAY;
    assign in_window = (channel >= CONVERT_DELAY) && (channel < ADC_CHANNELS + CONVERT_DELAY);
    assign last_xfer = (channel == LAST_XFER);

    assign busy = (state != READY);
    assign done = (state == STREAM) && stream_done;   // last busy cycle.

    // ~~~~~~~~~~~~~~~~~~~~
    // frame state machine
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state        <= READY;
            channel      <= '0;
            xfer_start   <= 1'b0;
            stream_start <= 1'b0;
            store_wr     <= '0;
        end else begin
            xfer_start   <= 1'b0;
            stream_start <= 1'b0;
            store_wr.en  <= 1'b0;
            case (state)
                READY: begin
                    if (record_start) begin
                        channel <= '0;
                        state   <= LOAD;
                    end
                end
                LOAD: begin
                    if (!xfer_busy) begin
                        xfer_start <= 1'b1;
                        state      <= TX;
                    end
                end
                TX: begin
                    state <= RX;
                end
                RX: begin
                    if (xfer_done) begin
                        store_wr <= '{en: in_window, addr: row_addr, row: reply};
                        if (last_xfer) begin
                            stream_start <= 1'b1;
                            state        <= STREAM;
                        end else begin
                            channel <= channel + 1'b1;
                            state   <= LOAD;
                        end
                    end
                end
                STREAM: begin
                    if (stream_done) begin
                        state <= READY;
                    end
                end
                default: begin
                    state <= READY;
                end
            endcase
        end
    end

    // command is latched only while the engine is idle.
    always_ff @(posedge clk) begin
        if (state == LOAD && !xfer_busy) begin
            xfer_cmd <= (channel < ADC_CHANNELS) ? convert_cmd : read_cmd;
        end
    end

endmodule

`default_nettype wire

// File: hdl/rhd_spi_engine.sv
`timescale 1ns/1ns
`default_nettype none

`include "rhd_defs.svh"

module rhd_spi_engine (
    input  wire                           clk,
    input  wire                           rstn,
    input  wire                           xfer_start,
    input  wire rhd_pkg::cmd_word_t       xfer_cmd,
    input  wire [`RHD_MISO_LINES-1:0]     miso,
    output logic                          cs,
    output logic                          sclk,
    output logic                          mosi,
    output logic                          xfer_busy,
    output logic                          xfer_done,
    output rhd_pkg::frame_row_t           reply
);

    import rhd_pkg::*;

    localparam int         MSB       = `RHD_SAMPLE_BITS - 1;
    localparam logic [3:0] LAST_HALF = 4'(`RHD_SCLK_HALF - 1);
    localparam logic [3:0] LAST_GAP  = 4'(`RHD_CS_GAP - 1);
    localparam logic [3:0] LAST_BIT  = 4'(`RHD_SAMPLE_BITS - 1);

    logic       in_gap;
    logic [3:0] half_cnt;
    logic [3:0] bit_cnt;
    logic [3:0] gap_cnt;
    logic       half_end;
    logic       gap_end;

    cmd_word_t                      tx_shift;
    sample_t [`RHD_MISO_LINES-1:0]  a_shift;
    sample_t [`RHD_MISO_LINES-1:0]  b_shift;

    assign half_end = xfer_busy && !in_gap && (half_cnt == LAST_HALF);
    assign gap_end  = xfer_busy && in_gap && (gap_cnt == LAST_GAP);

    // ~~~~~~~~~~~~~~~~~~~~
    // sclk and cs sequencing
    always_ff @(posedge clk) begin
        if (!rstn) begin
            xfer_busy <= 1'b0;
            xfer_done <= 1'b0;
            in_gap    <= 1'b0;
            cs        <= 1'b1;
            sclk      <= 1'b0;
            mosi      <= 1'b0;
            half_cnt  <= '0;
            bit_cnt   <= '0;
            gap_cnt   <= '0;
        end else begin
            xfer_done <= 1'b0;
            if (!xfer_busy) begin
                if (xfer_start) begin
                    xfer_busy <= 1'b1;
                    cs        <= 1'b0;
                    mosi      <= xfer_cmd[MSB];   // msb first.
                    half_cnt  <= '0;
                    bit_cnt   <= '0;
                end
            end else if (in_gap) begin
                gap_cnt <= gap_cnt + 1'b1;
                if (gap_end) begin
                    in_gap    <= 1'b0;
                    xfer_busy <= 1'b0;
                    xfer_done <= 1'b1;
                end
            end else if (half_end) begin
                half_cnt <= '0;
                sclk     <= !sclk;
                if (sclk) begin   // high half over, bit period done.
                    if (bit_cnt == LAST_BIT) begin
                        cs      <= 1'b1;
                        in_gap  <= 1'b1;
                        gap_cnt <= '0;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                        mosi    <= tx_shift[MSB];
                    end
                end
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // data shift registers
    always_ff @(posedge clk) begin
        if (xfer_start && !xfer_busy) begin
            tx_shift <= xfer_cmd << 1;
        end else if (half_end && sclk) begin
            tx_shift <= tx_shift << 1;
        end
        for (int l = 0; l < `RHD_MISO_LINES; l++) begin
            if (half_end && sclk) begin
                a_shift[l] <= {a_shift[l][MSB-1:0], miso[l]};   // end of high half.
            end
            if (half_end && !sclk) begin
                b_shift[l] <= {b_shift[l][MSB-1:0], miso[l]};   // end of low half.
            end
            if (gap_end) begin
                reply[l].a <= a_shift[l];
                reply[l].b <= b_shift[l];
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/rhd_frame_store.sv
`timescale 1ns/1ns
`default_nettype none

`include "rhd_defs.svh"

module rhd_frame_store (
    input  wire                      clk,
    input  wire rhd_pkg::row_write_t wr,
    input  wire rhd_pkg::channel_t   rd_addr,
    output rhd_pkg::frame_row_t      rd_row
);

    import rhd_pkg::*;

    localparam int ADDR_W = $clog2(`RHD_ADC_CHANNELS);

    // one row per channel, every line side by side.
    frame_row_t mem [`RHD_ADC_CHANNELS];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr[ADDR_W-1:0]] <= wr.row;
        end
        rd_row <= mem[rd_addr[ADDR_W-1:0]];   // one cycle read.
    end

endmodule

`default_nettype wire

// File: hdl/rhd_frame_streamer.sv
`timescale 1ns/1ns
`default_nettype none

`include "rhd_defs.svh"

module rhd_frame_streamer (
    input  wire                      clk,
    input  wire                      rstn,
    input  wire                      stream_start,
    input  wire rhd_pkg::frame_row_t rd_row,
    output rhd_pkg::channel_t        rd_addr,
    output logic                     sample_valid,
    output rhd_pkg::sample_index_t   sample_index,
    output rhd_pkg::sample_t         sample_data,
    output logic                     stream_done
);

    import rhd_pkg::*;

    localparam int               COLS       = 2 * `RHD_MISO_LINES;
    localparam int               COL_W      = $clog2(COLS);
    localparam channel_t         LAST_CH    = channel_t'(`RHD_ADC_CHANNELS - 1);
    localparam logic [COL_W-1:0] LAST_COL   = COL_W'(COLS - 1);
    localparam sample_index_t    LAST_INDEX = sample_index_t'(COLS * `RHD_ADC_CHANNELS - 1);

    logic             running;
    logic [COL_W-1:0] col;     // line and half, half in bit 0.
    logic [COL_W-1:0] col_q;
    channel_t         ch;
    sample_index_t    idx;

    assign rd_addr = ch;

    // column word out of the row read last cycle.
    assign sample_data = col_q[0] ? rd_row[col_q >> 1].b : rd_row[col_q >> 1].a;

    // ~~~~~~~~~~~~~~~~~~~~
    // address counters
    always_ff @(posedge clk) begin
        if (!rstn) begin
            running      <= 1'b0;
            col          <= '0;
            ch           <= '0;
            idx          <= '0;
            sample_valid <= 1'b0;
            stream_done  <= 1'b0;
        end else begin
            sample_valid <= running;   // lines up with the read latency.
            stream_done  <= sample_valid && (sample_index == LAST_INDEX);
            if (stream_start && !running) begin
                running <= 1'b1;
                col     <= '0;
                ch      <= '0;
                idx     <= '0;
            end else if (running) begin
                idx <= idx + 1'b1;
                if (ch == LAST_CH) begin
                    ch <= '0;
                    if (col == LAST_COL) begin
                        running <= 1'b0;
                    end else begin
                        col <= col + 1'b1;
                    end
                end else begin
                    ch <= ch + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        sample_index <= idx;
        col_q        <= col;
    end

endmodule

`default_nettype wire

// File: hdl/rhd_recorder.sv
`timescale 1ns/1ns
`default_nettype none

`include "rhd_defs.svh"

module rhd_recorder (
    input  wire                        clk,
    input  wire                        rstn,
    input  wire                        record_start,
    input  wire [`RHD_MISO_LINES-1:0]  miso,
    output logic                       busy,
    output logic                       done,
    output logic                       cs,
    output logic                       sclk,
    output logic                       mosi,
    output rhd_pkg::channel_t          channel,
    output logic                       sample_valid,
    output rhd_pkg::sample_index_t     sample_index,
    output rhd_pkg::sample_t           sample_data
);

    import rhd_pkg::*;

    logic       xfer_start;
    logic       xfer_busy;
    logic       xfer_done;
    cmd_word_t  xfer_cmd;
    frame_row_t reply;
    row_write_t store_wr;
    logic       stream_start;
    logic       stream_done;
    channel_t   rd_addr;
    frame_row_t rd_row;

    // ~~~~~~~~~~~~~~~~~~~~
    // producer
    rhd_sequencer rhd_sequencer_i (
        .clk          (clk),
        .rstn         (rstn),
        .record_start (record_start),
        .xfer_busy    (xfer_busy),
        .xfer_done    (xfer_done),
        .stream_done  (stream_done),
        .reply        (reply),
        .xfer_start   (xfer_start),
        .xfer_cmd     (xfer_cmd),
        .store_wr     (store_wr),
        .stream_start (stream_start),
        .channel      (channel),
        .busy         (busy),
        .done         (done)
    );

    rhd_spi_engine rhd_spi_engine_i (
        .clk        (clk),
        .rstn       (rstn),
        .xfer_start (xfer_start),
        .xfer_cmd   (xfer_cmd),
        .miso       (miso),
        .cs         (cs),
        .sclk       (sclk),
        .mosi       (mosi),
        .xfer_busy  (xfer_busy),
        .xfer_done  (xfer_done),
        .reply      (reply)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // buffer and consumer
    rhd_frame_store rhd_frame_store_i (
        .clk     (clk),
        .wr      (store_wr),
        .rd_addr (rd_addr),
        .rd_row  (rd_row)
    );

    rhd_frame_streamer rhd_frame_streamer_i (
        .clk          (clk),
        .rstn         (rstn),
        .stream_start (stream_start),
        .rd_row       (rd_row),
        .rd_addr      (rd_addr),
        .sample_valid (sample_valid),
        .sample_index (sample_index),
        .sample_data  (sample_data),
        .stream_done  (stream_done)
    );

endmodule

`default_nettype wire

// File: test/rhd_chip_model.sv
`timescale 1ns/1ns
`default_nettype none

`include "rhd_defs.svh"

module rhd_chip_model (
    input  wire                         cs,
    input  wire                         sclk,
    input  wire                         mosi,
    input  wire                         frame_start,
    input  wire  [7:0]                  frame_byte,
    output logic [`RHD_MISO_LINES-1:0]  miso
);

    import rhd_pkg::*;

    localparam int MSB  = `RHD_SAMPLE_BITS - 1;
    localparam int BITS = `RHD_SAMPLE_BITS;

    cmd_word_t  cmd_log [`RHD_FRAME_XFERS];   // decoded mosi words of the frame.
    int         cmd_count;
    int         rise_cnt;
    cmd_word_t  shift_in;
    cmd_word_t  prev_cmd;
    logic [7:0] byte_q;
    sample_t    a_word [`RHD_MISO_LINES];
    sample_t    b_word [`RHD_MISO_LINES];

    initial begin
        miso      = '0;
        cmd_count = 0;
        rise_cnt  = BITS;
        shift_in  = '0;
        byte_q    = '0;
    end

    always @(posedge frame_start) begin
        byte_q    = frame_byte;
        cmd_count = 0;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // reply words, first b bit out with cs
    always @(negedge cs) begin
        prev_cmd = (cmd_count >= `RHD_CONVERT_DELAY) ?
                   cmd_log[cmd_count - `RHD_CONVERT_DELAY] : '1;
        for (int l = 0; l < `RHD_MISO_LINES; l++) begin
            if (prev_cmd[MSB -: 2] == 2'b00) begin   // convert two commands back.
                a_word[l] = {byte_q ^ 8'(2 * l), 2'b00, prev_cmd[13:8]};
                b_word[l] = {byte_q ^ 8'(2 * l + 1), 2'b00, prev_cmd[13:8]};
            end else begin
                a_word[l] = '0;
                b_word[l] = '0;
            end
            miso[l] = b_word[l][MSB];
        end
        rise_cnt = 0;
    end

    always @(posedge sclk) begin
        if (!cs && rise_cnt < BITS) begin
            shift_in = {shift_in[MSB-1:0], mosi};
            for (int l = 0; l < `RHD_MISO_LINES; l++) begin
                miso[l] = a_word[l][MSB - rise_cnt];
            end
            rise_cnt++;
            if (rise_cnt == BITS && cmd_count < `RHD_FRAME_XFERS) begin
                cmd_log[cmd_count] = shift_in;
                cmd_count++;
            end
        end
    end

    always @(negedge sclk) begin
        if (rise_cnt > 0 && rise_cnt < BITS) begin
            for (int l = 0; l < `RHD_MISO_LINES; l++) begin
                miso[l] = b_word[l][MSB - rise_cnt];
            end
        end
    end

endmodule

`default_nettype wire

// File: test/rhd_recorder_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "rhd_defs.svh"

module rhd_recorder_checker (
    input wire clk,
    input wire rstn,
    input wire record_start,
    input wire busy,
    input wire done,
    input wire cs,
    input wire sclk,
    input wire mosi,
    input wire sample_valid
);

    localparam int STREAM_LEN = 2 * `RHD_MISO_LINES * `RHD_ADC_CHANNELS;

    int fail_count = 0;
    int valid_run;   // consecutive valid cycles so far.

    always_ff @(posedge clk) begin
        valid_run <= (rstn && sample_valid) ? valid_run + 1 : 0;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // reset and frame framing
    reset_idle: assert property (@(posedge clk)
        !rstn |=> cs && !busy && !done && !sample_valid)
        else begin $error("outputs not idle after reset"); fail_count++; end

    busy_start: assert property (@(posedge clk) disable iff (!rstn)
        $rose(busy) |-> $past(record_start))
        else begin $error("busy rose without record_start"); fail_count++; end

    stream_length: assert property (@(posedge clk) disable iff (!rstn)
        $fell(sample_valid) |-> valid_run == STREAM_LEN)
        else begin $error("sample_valid run length wrong"); fail_count++; end

    done_after_stream: assert property (@(posedge clk) disable iff (!rstn)
        $fell(sample_valid) |-> done)
        else begin $error("done missing after last sample"); fail_count++; end

    done_pulse: assert property (@(posedge clk) disable iff (!rstn)
        done |-> busy ##1 (!done && !busy))
        else begin $error("done not a single pulse ending busy"); fail_count++; end

    // ~~~~~~~~~~~~~~~~~~~~
    // spi bus
    mosi_stable: assert property (@(posedge clk) disable iff (!rstn)
        sclk |-> $stable(mosi))
        else begin $error("mosi changed while sclk high"); fail_count++; end

    sclk_in_cs: assert property (@(posedge clk) disable iff (!rstn)
        !$stable(sclk) |-> !$past(cs))
        else begin $error("sclk toggled with cs high"); fail_count++; end

endmodule

bind rhd_recorder rhd_recorder_checker rhd_recorder_checker_i (
    .clk          (clk),
    .rstn         (rstn),
    .record_start (record_start),
    .busy         (busy),
    .done         (done),
    .cs           (cs),
    .sclk         (sclk),
    .mosi         (mosi),
    .sample_valid (sample_valid)
);

`default_nettype wire

// File: test/rhd_recorder_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "rhd_defs.svh"

module rhd_recorder_tb;

    import rhd_pkg::*;

    localparam int NUM_FRAMES  = 3;
    localparam int SAMPLES     = 2 * `RHD_MISO_LINES * `RHD_ADC_CHANNELS;
    localparam int XFER_CYCLES = 1 + 2 * `RHD_SCLK_HALF * `RHD_SAMPLE_BITS + `RHD_CS_GAP;
    localparam int WATCHDOG_CYCLES =
        NUM_FRAMES * (`RHD_FRAME_XFERS * XFER_CYCLES + SAMPLES) * 3 / 2;

    logic                       clk;
    logic                       rstn;
    logic                       record_start;
    logic                       frame_start;
    logic [7:0]                 frame_byte;
    wire  [`RHD_MISO_LINES-1:0] miso;
    logic                       busy;
    logic                       done;
    logic                       cs;
    logic                       sclk;
    logic                       mosi;
    channel_t                   channel;
    logic                       sample_valid;
    sample_index_t              sample_index;
    sample_t                    sample_data;

    integer seed;
    int     cmd_errors;
    int     sample_errors;
    int     count_errors;
    int     checker_errors;
    int     done_count;
    int     sample_count;   // samples seen in the current frame.
    int     xfer_index;     // transactions finished in the current frame.
    logic   cs_q;

    rhd_recorder rhd_recorder_i (
        .clk          (clk),
        .rstn         (rstn),
        .record_start (record_start),
        .miso         (miso),
        .busy         (busy),
        .done         (done),
        .cs           (cs),
        .sclk         (sclk),
        .mosi         (mosi),
        .channel      (channel),
        .sample_valid (sample_valid),
        .sample_index (sample_index),
        .sample_data  (sample_data)
    );

    rhd_chip_model rhd_chip_model_i (
        .cs          (cs),
        .sclk        (sclk),
        .mosi        (mosi),
        .frame_start (frame_start),
        .frame_byte  (frame_byte),
        .miso        (miso)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = !clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // expected values
    function automatic cmd_word_t command_for(input int t);
        if (t < `RHD_ADC_CHANNELS) begin
            return {2'b00, 6'(t), 7'd0, 1'b1};
        end
        return {2'b11, 6'(`RHD_CHIP_ID_REG), 8'd0};
    endfunction

    function automatic sample_t expected_sample(input int idx);
        int col;
        int ch;
        col = idx / `RHD_ADC_CHANNELS;   // line * 2 + half.
        ch  = idx % `RHD_ADC_CHANNELS;
        return {frame_byte ^ 8'(col), 8'(ch)};
    endfunction

    always @(negedge clk) begin
        if (rstn && sample_valid) begin
            assert (sample_index == sample_index_t'(sample_count)) else begin
                sample_errors++;
                $display("** Error at %0t: sample_index %0d, expected %0d",
                         $time, sample_index, sample_count);
            end
            assert (sample_data == expected_sample(int'(sample_index))) else begin
                sample_errors++;
                $display("** Error at %0t: sample %0d is %h, expected %h", $time,
                         sample_index, sample_data, expected_sample(int'(sample_index)));
            end
            sample_count++;
        end
        if (rstn && busy && !cs) begin
            assert (channel == channel_t'(xfer_index)) else begin
                cmd_errors++;
                $display("** Error at %0t: channel %0d, expected %0d",
                         $time, channel, xfer_index);
            end
        end
        if (cs && !cs_q) begin
            xfer_index++;   // cs rises once per transaction.
        end
        cs_q = cs;
        if (rstn && done) begin
            done_count++;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // stimulus
    task automatic run_frame(input bit extra_start);
        @(negedge clk);
        frame_byte   = 8'($random(seed));
        sample_count = 0;
        xfer_index   = 0;
        record_start = 1'b1;
        frame_start  = 1'b1;
        @(negedge clk);
        record_start = 1'b0;
        frame_start  = 1'b0;
        if (extra_start) begin
            repeat (100) @(negedge clk);
            assert (busy) else begin
                count_errors++;
                $display("** Error at %0t: busy low before the extra record_start", $time);
            end
            record_start = 1'b1;   // must be ignored.
            @(negedge clk);
            record_start = 1'b0;
        end
        while (!done) @(negedge clk);
    endtask

    task automatic check_frame;
        assert (rhd_chip_model_i.cmd_count == `RHD_FRAME_XFERS) else begin
            count_errors++;
            $display("** Error at %0t: %0d commands in the frame, expected %0d",
                     $time, rhd_chip_model_i.cmd_count, `RHD_FRAME_XFERS);
        end
        for (int t = 0; t < `RHD_FRAME_XFERS; t++) begin
            assert (rhd_chip_model_i.cmd_log[t] === command_for(t)) else begin
                cmd_errors++;
                $display("** Error at %0t: command %0d is %h, expected %h", $time, t,
                         rhd_chip_model_i.cmd_log[t], command_for(t));
            end
        end
        assert (sample_count == SAMPLES) else begin
            count_errors++;
            $display("** Error at %0t: %0d samples streamed, expected %0d",
                     $time, sample_count, SAMPLES);
        end
    endtask

    initial begin
        seed           = 20;
        cmd_errors     = 0;
        sample_errors  = 0;
        count_errors   = 0;
        done_count     = 0;
        sample_count   = 0;
        xfer_index     = 0;
        cs_q           = 1'b1;
        rstn           = 1'b0;
        record_start   = 1'b0;
        frame_start    = 1'b0;
        frame_byte     = '0;
        repeat (4) @(negedge clk);
        rstn = 1'b1;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            run_frame(f == 1);
            check_frame();
        end
        repeat (5) @(negedge clk);
        assert (done_count == NUM_FRAMES) else begin
            count_errors++;
            $display("** Error at %0t: %0d done pulses, expected %0d",
                     $time, done_count, NUM_FRAMES);
        end
        checker_errors = rhd_recorder_i.rhd_recorder_checker_i.fail_count;
        $display("errors: %0d command, %0d sample, %0d count, %0d checker",
                 cmd_errors, sample_errors, count_errors, checker_errors);
        if (cmd_errors + sample_errors + count_errors + checker_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // watchdog.
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the frames never completed",
                 WATCHDOG_CYCLES);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+hdl
hdl/rhd_pkg.sv
hdl/rhd_sequencer.sv
hdl/rhd_spi_engine.sv
hdl/rhd_frame_store.sv
hdl/rhd_frame_streamer.sv
hdl/rhd_recorder.sv
test/rhd_chip_model.sv
test/rhd_recorder_checker.sv
test/rhd_recorder_tb.sv
